// File: hw/cacc_fp_pkg.sv
// ===============================================
// number formats of the convolution accumulator
// field widths, exponent biases and packed layouts
// of the fp48 data word, fp48 operand and fp32 result
// ===============================================
`default_nettype none

package cacc_fp_pkg;

  // exponent biases
  localparam int DATA_EXPO_BIAS = 30;
  localparam int OP_EXPO_BIAS   = 63;
  // fp32 bias 127 minus operand bias 63
  localparam int FP32_BIAS_ADJ  = 64;

  // datapath widths
  localparam int ALIGN_WIDTH    = 40;
  // aligned sum plus three cut bits
  localparam int SUM_WIDTH      = 44;
  localparam int LSD_DATA_WIDTH = 36;
  localparam int LSD_CNT_WIDTH  = 6;

  // data word exponent, bias 30
  typedef logic [5:0] data_expo_t;
  // data word mantissa, 18 integer and 20 fraction bits, unnormalized
  typedef logic signed [37:0] data_mant_t;

  // operand and partial exponent, bias 63
  typedef logic [7:0] op_expo_t;
  // operand mantissa, 2 integer and 38 fraction bits, normalized
  typedef logic signed [ALIGN_WIDTH-1:0] op_mant_t;

  // incoming data word, 44 bits
  typedef struct packed {
    data_expo_t expo;
    data_mant_t mant;
  } fp48_data_t;

  // operand and partial sum, 48 bits
  typedef struct packed {
    op_expo_t expo;
    op_mant_t mant;
  } fp48_op_t;

  // ieee single precision
  typedef struct packed {
    logic       sign;
    logic [7:0] expo;
    logic [22:0] frac;
  } fp32_t;

endpackage

`default_nettype wire

// File: hw/cacc_pipe_pkg.sv
// ===============================================
// records passed between the pipeline stages
// stage 1 to stage 2 and stage 2 to stage 3
// ===============================================
`default_nettype none

package cacc_pipe_pkg;

  import cacc_fp_pkg::*;

  // guard, round and sticky bits
  typedef logic [2:0] cut_bits_t;

  // aligned operands
  typedef struct packed {
    logic      valid;
    // last addition of a chain
    logic      fin;
    logic      nan;
    // common exponent after alignment
    op_expo_t  expo;
    op_mant_t  di_mant;
    op_mant_t  oi_mant;
    // bits shifted out of the smaller operand
    cut_bits_t cut;
  } align_rec_t;

  // normalized sum
  typedef struct packed {
    logic                   valid;
    logic                   fin;
    logic                   nan;
    op_expo_t               expo;
    // 40 bit mantissa then guard then sticky
    logic [ALIGN_WIDTH+1:0] sum;
  } sum_rec_t;

endpackage

`default_nettype wire

// File: hw/cacc_lsd.sv
// ===============================================
// leading sign detector
// counts redundant sign bits of a signed vector
// ===============================================
`timescale 1ns/10ps
`default_nettype none

module cacc_lsd #(
  parameter int WIDTH = cacc_fp_pkg::LSD_DATA_WIDTH
) (
  input  wire  [WIDTH-1:0]                      value,
  output logic [cacc_fp_pkg::LSD_CNT_WIDTH-1:0] cnt
);

  import cacc_fp_pkg::*;

  // bits that differ from the sign
  logic [WIDTH-2:0] diff;

  assign diff = value[WIDTH-2:0] ^ {(WIDTH-1){value[WIDTH-1]}};

  // highest differing bit wins
  // all bits equal to sign gives WIDTH-1
  always_comb begin
    cnt = LSD_CNT_WIDTH'(WIDTH - 1);
    for (int i = 0; i < WIDTH - 1; i++) begin
      if (diff[i]) begin
        cnt = LSD_CNT_WIDTH'(WIDTH - 2 - i);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/cacc_fp48_align.sv
// ===============================================
// stage 1 of the fp48 adder
// masks and classifies both inputs, normalizes the
// data word and aligns both mantissas to one exponent
// ===============================================
`timescale 1ns/10ps
`default_nettype none

module cacc_fp48_align (
  input  wire                       nvdla_core_clk,
  input  wire                       nvdla_core_rstn,
  input  wire                       in_valid,
  input  wire                       in_sel,
  input  wire                       in_op_valid,
  input  wire cacc_fp_pkg::fp48_data_t in_data,
  input  wire cacc_fp_pkg::fp48_op_t   in_op,
  output cacc_pipe_pkg::align_rec_t rec
);

  import cacc_fp_pkg::*;
  import cacc_pipe_pkg::*;

  fp48_op_t                   op_masked;
  logic [LSD_DATA_WIDTH-1:0]  di_mant;
  logic [LSD_CNT_WIDTH-1:0]   di_lead;
  logic [6:0]                 di_expm;
  logic [LSD_DATA_WIDTH-1:0]  di_manm;
  logic                       di_zero;
  logic                       di_nan;
  logic                       oi_zero;
  logic                       oi_nan;
  logic                       in_nan;
  op_mant_t                   di_mans;
  op_mant_t                   oi_mans;
  op_expo_t                   di_expo;
  op_expo_t                   oi_expo;
  op_expo_t                   max_expo;
  logic [ALIGN_WIDTH+2:0]     di_align;
  logic [ALIGN_WIDTH+2:0]     oi_align;
  cut_bits_t                  cut_nxt;
  logic                       valid_q;
  logic                       fin_q;
  logic                       nan_q;
  op_expo_t                   expo_q;
  op_mant_t                   di_mant_q;
  op_mant_t                   oi_mant_q;
  cut_bits_t                  cut_q;

  // arithmetic right shift, returns mantissa then guard round sticky
  function automatic logic [ALIGN_WIDTH+2:0] align_mant(input op_mant_t m,
                                                        input op_expo_t sh);
    logic [2*ALIGN_WIDTH-1:0] wide;
    wide = $signed({m, {ALIGN_WIDTH{1'b0}}}) >>> sh;
    return {wide[2*ALIGN_WIDTH-1:ALIGN_WIDTH], wide[ALIGN_WIDTH-1:ALIGN_WIDTH-2],
            |wide[ALIGN_WIDTH-3:0]};
  endfunction

  // ===============================================
  // classify
  // ===============================================
  // masked operand reads as zero
  assign op_masked = in_op_valid ? in_op : '0;

  assign di_zero = ~(|in_data.mant);
  assign di_nan  = &in_data.expo;
  assign oi_zero = ~(|op_masked.mant);
  assign oi_nan  = &op_masked.expo;
  assign in_nan  = di_nan | oi_nan;

  // ===============================================
  // normalize data word
  // ===============================================
  // top two integer bits assumed to be sign extension
  assign di_mant = in_data.mant[LSD_DATA_WIDTH-1:0];

  cacc_lsd #(.WIDTH(LSD_DATA_WIDTH)) u_lsd (
    .value (di_mant),
    .cnt   (di_lead)
  );

  assign di_manm = di_mant << di_lead;
  // rebias, plus 14 for 34 padded fraction bits against 20 data fraction bits
  assign di_expm = 7'(in_data.expo) + 7'(OP_EXPO_BIAS - DATA_EXPO_BIAS + 14) - 7'(di_lead);

  // nan keeps top mantissa bits of the nan input only
  assign di_mans = oi_nan ? '0 :
                   di_nan ? {in_data.mant[37:27], 29'b0} :
                   {di_manm, 4'b0};
  assign oi_mans = oi_nan ? {op_masked.mant[39:29], 29'b0} :
                   di_nan ? '0 :
                   op_masked.mant;

  assign di_expo = in_nan ? '1 : di_zero ? '0 : {1'b0, di_expm};
  assign oi_expo = in_nan ? '1 : oi_zero ? '0 : op_masked.expo;

  // ===============================================
  // align to larger exponent
  // ===============================================
  assign max_expo = (di_expo > oi_expo) ? di_expo : oi_expo;
  assign di_align = align_mant(di_mans, max_expo - di_expo);
  assign oi_align = align_mant(oi_mans, max_expo - oi_expo);

  // keep cut bits of smaller operand only
  assign cut_nxt = (di_expo > oi_expo) ? oi_align[2:0] :
                   (di_expo < oi_expo) ? di_align[2:0] : '0;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      valid_q <= 1'b0;
      fin_q   <= 1'b0;
    end else begin
      valid_q <= in_valid;
      fin_q   <= in_valid & in_sel;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (in_valid) begin
      nan_q     <= in_nan;
      expo_q    <= max_expo;
      di_mant_q <= di_align[ALIGN_WIDTH+2:3];
      oi_mant_q <= oi_align[ALIGN_WIDTH+2:3];
      cut_q     <= cut_nxt;
    end
  end

  assign rec = '{valid: valid_q, fin: fin_q, nan: nan_q, expo: expo_q,
                 di_mant: di_mant_q, oi_mant: oi_mant_q, cut: cut_q};

endmodule

`default_nettype wire

// File: hw/cacc_fp48_sum_nrml.sv
// ===============================================
// stage 2 of the fp48 adder
// adds the aligned mantissas and renormalizes the
// sum to two integer bits with guard and sticky
// ===============================================
`timescale 1ns/10ps
`default_nettype none

module cacc_fp48_sum_nrml (
  input  wire                         nvdla_core_clk,
  input  wire                         nvdla_core_rstn,
  input  wire cacc_pipe_pkg::align_rec_t rec_in,
  output cacc_pipe_pkg::sum_rec_t     rec
);

  import cacc_fp_pkg::*;
  import cacc_pipe_pkg::*;

  logic signed [ALIGN_WIDTH:0]  mant_sum;
  logic [SUM_WIDTH-1:0]         sum_total;
  logic [LSD_CNT_WIDTH-1:0]     sum_lead;
  op_expo_t                     expo_nrml;
  logic signed [SUM_WIDTH:0]    sum_comp;
  logic [SUM_WIDTH:0]           sum_shift;
  logic [ALIGN_WIDTH+1:0]       sum_nxt;
  logic                         valid_q;
  logic                         fin_q;
  logic                         nan_q;
  op_expo_t                     expo_q;
  logic [ALIGN_WIDTH+1:0]       sum_q;

  // one extra integer bit for the carry
  assign mant_sum  = $signed(rec_in.di_mant) + $signed(rec_in.oi_mant);
  assign sum_total = {mant_sum, rec_in.cut};

  cacc_lsd #(.WIDTH(SUM_WIDTH)) u_lsd (
    .value (sum_total),
    .cnt   (sum_lead)
  );

  // sum has three integer bits, target has two
  assign expo_nrml = rec_in.expo + 8'd1 - 8'(sum_lead);

  // ===============================================
  // renormalize
  // ===============================================
  assign sum_comp = {sum_total, 1'b0};

  // no redundant sign means carry out, shift right
  assign sum_shift = (sum_lead != '0) ? (sum_comp <<< (sum_lead - 6'd1)) :
                                        (sum_comp >>> 1);

  // mantissa and guard, low bits fold into sticky
  // nan passes the raw sum without rounding bits
  assign sum_nxt = rec_in.nan ? {mant_sum[ALIGN_WIDTH-1:0], 2'b00} :
                                {sum_shift[SUM_WIDTH-1:3], |sum_shift[2:0]};

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      valid_q <= 1'b0;
      fin_q   <= 1'b0;
    end else begin
      valid_q <= rec_in.valid;
      fin_q   <= rec_in.fin;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rec_in.valid) begin
      nan_q  <= rec_in.nan;
      expo_q <= expo_nrml;
      sum_q  <= sum_nxt;
    end
  end

  assign rec = '{valid: valid_q, fin: fin_q, nan: nan_q, expo: expo_q, sum: sum_q};

endmodule

`default_nettype wire

// File: hw/cacc_fp48_round.sv
// ===============================================
// stage 3 of the fp48 adder
// rounds the sum at half and drives the partial
// result and the pulse for a final conversion
// ===============================================
`timescale 1ns/10ps
`default_nettype none

module cacc_fp48_round (
  input  wire                       nvdla_core_clk,
  input  wire                       nvdla_core_rstn,
  input  wire cacc_pipe_pkg::sum_rec_t rec_in,
  output cacc_fp_pkg::fp48_op_t     out_partial_data,
  output logic                      out_partial_valid,
  output logic                      final_take
);

  import cacc_fp_pkg::*;
  import cacc_pipe_pkg::*;

  logic                         sum_sign;
  op_mant_t                     sum_effect;
  logic                         sum_guard;
  logic                         sum_stick;
  logic                         point5;
  logic signed [ALIGN_WIDTH:0]  sum_round;
  logic                         carry_pos;
  logic                         carry_neg;
  op_mant_t                     mant_nmlz;
  logic                         mant_zero;
  op_expo_t                     expo_nmlz;
  op_expo_t                     expo_nxt;
  op_expo_t                     expo_q;
  op_mant_t                     mant_q;

  assign sum_sign   = rec_in.sum[ALIGN_WIDTH+1];
  assign sum_effect = rec_in.sum[ALIGN_WIDTH+1:2];
  assign sum_guard  = rec_in.sum[1];
  assign sum_stick  = rec_in.sum[0];

  // half rounds up in magnitude for both signs
  assign point5    = sum_guard & (~sum_sign | sum_stick);
  assign sum_round = $signed(sum_effect) + $signed({1'b0, point5});

  // 01.111..1 plus one ulp overflows to 10.000
  assign carry_pos = ~sum_sign & (&sum_effect[ALIGN_WIDTH-2:0]) & point5;
  // 10.111..1 plus one ulp gives 11.000, no longer normalized
  assign carry_neg = sum_sign & ~sum_effect[ALIGN_WIDTH-2] &
                     (&sum_effect[ALIGN_WIDTH-3:0]) & point5;

  // one bit correction either way
  assign mant_nmlz = carry_neg ? {sum_round[ALIGN_WIDTH-2:0], 1'b0} :
                     carry_pos ? sum_round[ALIGN_WIDTH:1] :
                                 sum_round[ALIGN_WIDTH-1:0];
  assign mant_zero = ~(|mant_nmlz);

  assign expo_nmlz = carry_neg ? rec_in.expo - 8'd1 : rec_in.expo + 8'(carry_pos);
  assign expo_nxt  = rec_in.nan ? '1 : mant_zero ? '0 : expo_nmlz;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_partial_valid <= 1'b0;
      final_take        <= 1'b0;
    end else begin
      // last item of a chain goes to fp32 only
      out_partial_valid <= rec_in.valid & ~rec_in.fin;
      final_take        <= rec_in.fin;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rec_in.valid) begin
      expo_q <= expo_nxt;
      mant_q <= mant_nmlz;
    end
  end

  assign out_partial_data = '{expo: expo_q, mant: mant_q};

endmodule

`default_nettype wire

// File: hw/cacc_fp32_convert.sv
// ===============================================
// stage 4 of the fp48 adder
// converts a final partial result to fp32
// ===============================================
`timescale 1ns/10ps
`default_nettype none

module cacc_fp32_convert (
  input  wire                     nvdla_core_clk,
  input  wire                     nvdla_core_rstn,
  input  wire cacc_fp_pkg::fp48_op_t partial,
  input  wire                     final_take,
  output cacc_fp_pkg::fp32_t      out_final_data,
  output logic                    out_final_valid
);

  import cacc_fp_pkg::*;

  logic                   partial_sign;
  logic [ALIGN_WIDTH-2:0] partial_umant;
  logic                   partial_neg2;
  logic                   partial_nan;
  logic                   partial_zero;
  logic [ALIGN_WIDTH-2:0] mant_abs;
  logic [23:0]            mant_effect;
  logic                   point5;
  logic                   carry;
  logic [24:0]            mant_round;
  logic [22:0]            frac;
  op_expo_t               expo_round;
  op_expo_t               expo_nxt;
  fp32_t                  result;

  assign partial_sign  = partial.mant[ALIGN_WIDTH-1];
  assign partial_umant = partial.mant[ALIGN_WIDTH-2:0];
  // exactly minus two has no magnitude bits below the sign
  assign partial_neg2  = partial_sign & ~(|partial_umant);
  assign partial_nan   = &partial.expo;
  assign partial_zero  = ~(|partial.mant);

  // sign magnitude, hidden one lands on the top bit
  assign mant_abs = partial_sign ? (~partial_umant + 39'd1) : partial_umant;

  // 24 bits kept, next bit rounds
  assign mant_effect = mant_abs[38:15];
  assign point5      = mant_abs[14];
  assign carry       = (&mant_effect) & point5;
  assign mant_round  = {1'b0, mant_effect} + 25'(point5);

  // renormalize on carry, hidden one dropped
  assign frac = partial_nan ? {13'b0, partial_umant[38:29]} : 23'(mant_round >> carry);

  assign expo_round = partial.expo + 8'(FP32_BIAS_ADJ) + 8'(carry | partial_neg2);
  assign expo_nxt   = partial_zero ? '0 : partial_nan ? '1 : expo_round;

  assign result = '{sign: partial_sign, expo: expo_nxt, frac: frac};

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_final_valid <= 1'b0;
    end else begin
      out_final_valid <= final_take;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (final_take) begin
      out_final_data <= result;
    end
  end

endmodule

`default_nettype wire

// File: hw/cacc_fp48_calc.sv
// ===============================================
// fp48 accumulator adder, four stage pipeline
// returns a partial sum or a rounded fp32 result
// ===============================================
`timescale 1ns/10ps
`default_nettype none

module cacc_fp48_calc (
  input  wire                          nvdla_core_clk,
  input  wire                          nvdla_core_rstn,
  input  wire                          in_valid,
  input  wire                          in_sel,
  input  wire cacc_fp_pkg::fp48_data_t in_data,
  input  wire cacc_fp_pkg::fp48_op_t   in_op,
  input  wire                          in_op_valid,
  output wire cacc_fp_pkg::fp48_op_t   out_partial_data,
  output wire                          out_partial_valid,
  output wire cacc_fp_pkg::fp32_t      out_final_data,
  output wire                          out_final_valid
);

  import cacc_pipe_pkg::*;

  align_rec_t align_rec;
  sum_rec_t   sum_rec;
  logic       final_take;

  // stage 1, mask normalize align
  cacc_fp48_align u_align (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (in_valid),
    .in_sel          (in_sel),
    .in_op_valid     (in_op_valid),
    .in_data         (in_data),
    .in_op           (in_op),
    .rec             (align_rec)
  );

  // stage 2, add and renormalize
  cacc_fp48_sum_nrml u_sum_nrml (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .rec_in          (align_rec),
    .rec             (sum_rec)
  );

  // stage 3, round and partial output
  cacc_fp48_round u_round (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .rec_in            (sum_rec),
    .out_partial_data  (out_partial_data),
    .out_partial_valid (out_partial_valid),
    .final_take        (final_take)
  );

  // stage 4, fp32 output
  cacc_fp32_convert u_convert (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .partial         (out_partial_data),
    .final_take      (final_take),
    .out_final_data  (out_final_data),
    .out_final_valid (out_final_valid)
  );

endmodule

`default_nettype wire

// File: verification/cacc_clk_gen.sv
// ==================================================
// testbench clock and reset for the fp48 adder
// free running clock, reset held low for a few cycles
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module cacc_clk_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #(PERIOD / 2) nvdla_core_clk = ~nvdla_core_clk;
  end

  // released on a falling edge, away from the sampling edge
  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/cacc_fp48_calc_tb.sv
// ==================================================
// testbench of the fp48 accumulator adder
// random integer stimulus with an exact fp32 model
// and a monitor that checks the exact latency
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module cacc_fp48_calc_tb;

  import cacc_fp_pkg::*;

  localparam int CLK_PERIOD    = 100;
  localparam int PART_LATENCY  = 3;
  localparam int FINAL_LATENCY = 4;
  localparam int N_SINGLE      = 40;
  localparam int N_PAIR        = 40;
  localparam int N_CHAIN       = 8;
  localparam int MAX_CHAIN     = 6;
  localparam int N_SPECIAL     = 4;
  // zero, data nan and operand nan groups
  localparam int N_ITEMS       = N_SINGLE + N_PAIR + N_CHAIN * MAX_CHAIN + 3 * N_SPECIAL;
  localparam int WATCHDOG_CYC  = N_ITEMS * 10 + 100;
  // ieee single precision exponent bias
  localparam int FP32_BIAS     = 127;

  // expected partial result and the time it is due
  typedef struct packed {
    logic [63:0] due;
    fp48_op_t    data;
  } part_exp_t;

  // nan results are checked on the exponent only
  typedef struct packed {
    logic [63:0] due;
    logic        nan;
    fp32_t       data;
  } final_exp_t;

  logic       nvdla_core_clk;
  logic       nvdla_core_rstn;
  logic       in_valid;
  logic       in_sel;
  fp48_data_t in_data;
  fp48_op_t   in_op;
  logic       in_op_valid;
  fp48_op_t   out_partial_data;
  logic       out_partial_valid;
  fp32_t      out_final_data;
  logic       out_final_valid;

  int         seed = 52;
  part_exp_t  part_q[$];
  final_exp_t final_q[$];

  cacc_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) clk_gen_inst (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn)
  );

  cacc_fp48_calc cacc_fp48_calc_inst (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .in_valid          (in_valid),
    .in_sel            (in_sel),
    .in_data           (in_data),
    .in_op             (in_op),
    .in_op_valid       (in_op_valid),
    .out_partial_data  (out_partial_data),
    .out_partial_valid (out_partial_valid),
    .out_final_data    (out_final_data),
    .out_final_valid   (out_final_valid)
  );

  // ==================================================
  // reference model
  // ==================================================
  // signed integer with magnitude below 2^bits
  function automatic int rand_int(input int bits);
    return $random(seed) % (1 << bits);
  endfunction

  function automatic fp48_op_t random_op();
    logic [63:0] bits;
    bits = {$random(seed), $random(seed)};
    return bits[47:0];
  endfunction

  // integer n at the data bias with 20 fraction bits
  function automatic fp48_data_t data_from_int(input int n);
    fp48_data_t d;
    d.expo = data_expo_t'(DATA_EXPO_BIAS);
    d.mant = data_mant_t'(longint'(n) <<< 20);
    return d;
  endfunction

  // normalized operand where sign and next bit differ
  function automatic fp48_op_t op_from_int(input longint m);
    fp48_op_t               o;
    logic [ALIGN_WIDTH-1:0] mant;
    int                     e;
    o = '0;
    if (m != 0) begin
      mant = ALIGN_WIDTH'(m);
      // binary point sits below bit 38
      e = OP_EXPO_BIAS + 38;
      while (mant[ALIGN_WIDTH-1] == mant[ALIGN_WIDTH-2]) begin
        mant = mant << 1;
        e = e - 1;
      end
      o.expo = op_expo_t'(e);
      o.mant = mant;
    end
    return o;
  endfunction

  // exact fp32 of a small integer by sign and magnitude
  function automatic fp32_t fp32_from_int(input longint v);
    fp32_t  f;
    longint mag;
    int     top;
    f = '0;
    if (v != 0) begin
      mag = (v < 0) ? -v : v;
      top = 0;
      // leading one search
      for (int i = 0; i < 40; i++) begin
        if (mag[i]) begin
          top = i;
        end
      end
      f.sign = (v < 0);
      f.expo = 8'(FP32_BIAS + top);
      // hidden one drops out of the 23 bit field
      f.frac = 23'(mag << (23 - top));
    end
    return f;
  endfunction

  // ==================================================
  // checks
  // ==================================================
  task automatic abort_run(input string reason);
    $display("%0t ns: %s", $time, reason);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // ==================================================
  // stimulus
  // ==================================================
  // drive one item on this falling edge and record what it must give
  task automatic send_item(input fp48_data_t data, input fp48_op_t op, input logic op_valid,
                           input logic sel, input logic nan, input longint total);
    part_exp_t  pe;
    final_exp_t fe;
    in_valid    = 1'b1;
    in_sel      = sel;
    in_data     = data;
    in_op       = op;
    in_op_valid = op_valid;
    if (sel) begin
      fe.due  = $time + FINAL_LATENCY * CLK_PERIOD;
      fe.nan  = nan;
      fe.data = fp32_from_int(total);
      final_q.push_back(fe);
    end else begin
      pe.due  = $time + PART_LATENCY * CLK_PERIOD;
      pe.data = op_from_int(total);
      part_q.push_back(pe);
    end
    @(negedge nvdla_core_clk);
    // idle select and mask toggle freely
    in_valid    = 1'b0;
    in_sel      = $random(seed);
    in_op_valid = $random(seed);
  endtask

  // partial sum to feed back into the next addition
  task automatic wait_partial(output fp48_op_t op);
    int waited;
    waited = 0;
    while (!out_partial_valid && waited < 10) begin
      @(negedge nvdla_core_clk);
      waited = waited + 1;
    end
    if (!out_partial_valid) begin
      abort_run("partial result did not arrive within 10 cycles");
    end else begin
      op = out_partial_data;
    end
  endtask

  initial begin
    int         n;
    int         m;
    int         len;
    int         waited;
    longint     acc;
    fp48_data_t d;
    fp48_op_t   o;
    fp48_op_t   fb;
    in_valid    = 1'b0;
    in_sel      = 1'b0;
    in_op_valid = 1'b0;
    in_data     = '0;
    in_op       = '0;
    @(posedge nvdla_core_rstn);
    // a few idle cycles with both valids low
    repeat (3) @(negedge nvdla_core_clk);

    // single final adds with the operand masked off
    for (int i = 0; i < N_SINGLE; i++) begin
      n = rand_int(15);
      send_item(data_from_int(n), random_op(), 1'b0, 1'b1, 1'b0, longint'(n));
    end

    // data plus operand and mostly final
    for (int i = 0; i < N_PAIR; i++) begin
      n = rand_int(15);
      m = rand_int(21);
      send_item(data_from_int(n), op_from_int(longint'(m)), 1'b1,
                ($random(seed) & 3) != 0, 1'b0, longint'(n) + longint'(m));
    end

    // accumulation chains with the partial fed back
    for (int c = 0; c < N_CHAIN; c++) begin
      len = 2 + int'($unsigned($random(seed)) % 5);
      acc = 0;
      fb  = '0;
      for (int k = 0; k < len; k++) begin
        n   = rand_int(15);
        acc = acc + n;
        send_item(data_from_int(n), fb, k != 0, k == len - 1, 1'b0, acc);
        if (k != len - 1) begin
          wait_partial(fb);
        end
      end
    end

    // zero data at any exponent but nan
    for (int i = 0; i < N_SPECIAL; i++) begin
      d      = data_from_int(0);
      d.expo = data_expo_t'($unsigned($random(seed)) % 63);
      send_item(d, random_op(), 1'b0, 1'b1, 1'b0, 0);
    end

    // nan payload kept nonzero since an all zero payload reads as zero downstream
    for (int i = 0; i < N_SPECIAL; i++) begin
      d          = data_from_int(0);
      d.expo     = '1;
      d.mant     = data_mant_t'(random_op());
      d.mant[37] = 1'b1;
      send_item(d, random_op(), 1'b0, 1'b1, 1'b1, 0);
    end
    for (int i = 0; i < N_SPECIAL; i++) begin
      o          = random_op();
      o.expo     = '1;
      o.mant[38] = 1'b1;
      send_item(data_from_int(rand_int(15)), o, 1'b1, 1'b1, 1'b1, 0);
    end

    // drain the pipeline
    waited = 0;
    while ((part_q.size() != 0 || final_q.size() != 0) && waited < 20) begin
      @(negedge nvdla_core_clk);
      waited = waited + 1;
    end
    if (part_q.size() != 0 || final_q.size() != 0) begin
      abort_run("expected results still outstanding after the last item");
    end else begin
      repeat (2) @(negedge nvdla_core_clk);
      $display("TEST PASSED");
      $finish;
    end
  end

  // ==================================================
  // output monitor
  // ==================================================
  // registered outputs are stable at the falling edge
  initial begin
    logic       exp_pv;
    logic       exp_fv;
    part_exp_t  pe;
    final_exp_t fe;
    @(posedge nvdla_core_clk);
    forever begin
      @(negedge nvdla_core_clk);
      exp_pv = (part_q.size() != 0) && (part_q[0].due == $time);
      check_value("out_partial_valid", out_partial_valid, exp_pv);
      if (exp_pv) begin
        pe = part_q.pop_front();
        check_value("out_partial_data", out_partial_data, pe.data);
      end
      exp_fv = (final_q.size() != 0) && (final_q[0].due == $time);
      check_value("out_final_valid", out_final_valid, exp_fv);
      if (exp_fv) begin
        fe = final_q.pop_front();
        if (fe.nan) begin
          check_value("out_final_data nan exponent", out_final_data.expo, 8'hff);
        end else begin
          check_value("out_final_data", out_final_data, fe.data);
        end
      end
    end
  end

  // watchdog allows ten cycles per item plus slack
  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    abort_run("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire

// File: vlog.f
hw/cacc_fp_pkg.sv
hw/cacc_pipe_pkg.sv
hw/cacc_lsd.sv
hw/cacc_fp48_align.sv
hw/cacc_fp48_sum_nrml.sv
hw/cacc_fp48_round.sv
hw/cacc_fp32_convert.sv
hw/cacc_fp48_calc.sv
verification/cacc_clk_gen.sv
verification/cacc_fp48_calc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the fp48 adder testbench with verilator, run it and look for the pass line
verilator --binary --timing -Wno-fatal -f vlog.f --top-module cacc_fp48_calc_tb \
  -o cacc_fp48_calc_sim \
  && ./obj_dir/cacc_fp48_calc_sim | tee /dev/stderr | grep -q "TEST PASSED" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }
